/* hdl/nanorv32_pkg.sv */
// Shared widths, micro ROM bounds, vectors and bus types for the RV32 fetch front end
`default_nettype none

package nanorv32_pkg;

   // Word and address widths
   localparam int data_width      = 32;
   localparam int urom_addr_width = 5;
   localparam int pc_width        = 32;

   // Micro ROM sequence bounds, first and last entry of each
   localparam logic [urom_addr_width-1:0] urom_reset_first = 5'd0;
   localparam logic [urom_addr_width-1:0] urom_reset_last  = 5'd1;
   localparam logic [urom_addr_width-1:0] urom_entry_first = 5'd2;
   localparam logic [urom_addr_width-1:0] urom_entry_last  = 5'd18;
   localparam logic [urom_addr_width-1:0] urom_exit_first  = 5'd19;
   localparam logic [urom_addr_width-1:0] urom_exit_last   = 5'd20;

   // Fetch targets after the reset and interrupt entry sequences
   localparam logic [pc_width-1:0] reset_vector = 32'h0000_0000;
   localparam logic [pc_width-1:0] irq_vector   = 32'h0000_0040;

   // Sequence requested from the micro sequencer
   typedef enum logic [1:0] {
      useq_none,
      useq_reset,
      useq_entry,
      useq_exit
   } useq_kind_t;

   // Origin of a stream word
   typedef enum logic {
      src_mem,
      src_urom
   } inst_src_t;

   // One word on the instruction stream
   typedef struct packed {
      logic                  valid;
      logic [data_width-1:0] word;
      // Only meaningful for memory words
      logic [pc_width-1:0]   pc;
      inst_src_t             src;
   } inst_stream_t;

   // APB master side, read only
   typedef struct packed {
      logic                psel;
      logic                penable;
      logic [pc_width-1:0] paddr;
   } apb_req_t;

   // APB slave side
   typedef struct packed {
      logic [data_width-1:0] prdata;
      logic                  pready;
   } apb_rsp_t;

endpackage

`default_nettype wire

/* hdl/nanorv32_urom.sv */
// Micro ROM with the reset, interrupt entry and interrupt exit instruction sequences
`default_nettype none

module nanorv32_urom (
   input  logic [nanorv32_pkg::urom_addr_width-1:0] addr,
   output logic [nanorv32_pkg::data_width-1:0]      dout
);

   // Asynchronous table, zero latency from addr to dout
   always_comb begin
      case (addr)
         // Reset sequence
         5'd0:    dout = 32'h00100093;
         5'd1:    dout = 32'h00000013;
         // Interrupt entry, saves context below the stack pointer
         5'd2:    dout = 32'hfe112e23;
         5'd3:    dout = 32'hfe212c23;
         5'd4:    dout = 32'hfe512a23;
         5'd5:    dout = 32'hfe612823;
         5'd6:    dout = 32'hfe712623;
         5'd7:    dout = 32'hfea12423;
         5'd8:    dout = 32'hfeb12223;
         5'd9:    dout = 32'hfec12023;
         5'd10:   dout = 32'hfcd12e23;
         5'd11:   dout = 32'hfce12c23;
         5'd12:   dout = 32'hfcf12a23;
         5'd13:   dout = 32'hfff00093;
         5'd14:   dout = 32'h00000097;
         5'd15:   dout = 32'hfc112823;
         // Stack adjust, then jump through the vector table
         5'd16:   dout = 32'hfd010113;
         5'd17:   dout = 32'h08002103;
         5'd18:   dout = 32'h00010067;
         // Interrupt exit
         5'd19:   dout = 32'h00300093;
         5'd20:   dout = 32'h00000013;
         // Unused entries read as zero
         default: dout = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/nanorv32_useq.sv */
// Micro sequencer that steps the micro ROM through one requested sequence
`default_nettype none

module nanorv32_useq (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                seq_start,
   input  nanorv32_pkg::useq_kind_t            seq_kind,
   input  logic                                seq_step,
   output logic [nanorv32_pkg::data_width-1:0] urom_word,
   output logic                                urom_valid,
   output logic                                seq_busy
);

   import nanorv32_pkg::*;

   // Current ROM entry and last entry of the active sequence
   logic [urom_addr_width-1:0] addr;
   logic [urom_addr_width-1:0] last_addr;

   // Bounds chosen by the requested kind
   logic [urom_addr_width-1:0] first_sel;
   logic [urom_addr_width-1:0] last_sel;

   // High from the cycle after seq_start until the last entry is taken
   logic busy;

   // Sequence bounds lookup
   always_comb begin
      case (seq_kind)
         useq_entry: begin
            first_sel = urom_entry_first;
            last_sel  = urom_entry_last;
         end
         useq_exit: begin
            first_sel = urom_exit_first;
            last_sel  = urom_exit_last;
         end
         default: begin
            first_sel = urom_reset_first;
            last_sel  = urom_reset_last;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr      <= urom_reset_first;
         last_addr <= urom_reset_last;
         busy      <= 1'b0;
      end else if (seq_start) begin
         // A none request loads bounds but plays nothing
         addr      <= first_sel;
         last_addr <= last_sel;
         busy      <= (seq_kind != useq_none);
      end else if (seq_step && busy) begin
         if (addr == last_addr) begin
            // Last entry taken by the fetch unit
            busy <= 1'b0;
         end else begin
            addr <= addr + 1'b1;
         end
      end
   end

   nanorv32_urom u_urom (
      .addr (addr),
      .dout (urom_word)
   );

   // ROM word is valid for as long as the sequence runs
   assign urom_valid = busy;
   assign seq_busy   = busy;

endmodule

`default_nettype wire

/* hdl/nanorv32_ifetch.sv */
// Fetch unit with APB reads, micro ROM playback, interrupt PC save and restore
`default_nettype none

module nanorv32_ifetch (
   input  logic                                clk,
   input  logic                                rst_n,
   output nanorv32_pkg::apb_req_t              apb_req,
   input  nanorv32_pkg::apb_rsp_t              apb_rsp,
   input  logic                                irq_req,
   input  logic                                irq_ret,
   output logic                                irq_ack,
   output nanorv32_pkg::inst_stream_t          inst,
   input  logic                                inst_ready,
   output logic                                seq_start,
   output nanorv32_pkg::useq_kind_t            seq_kind,
   output logic                                seq_step,
   input  logic [nanorv32_pkg::data_width-1:0] urom_word,
   input  logic                                urom_valid,
   input  logic                                seq_busy
);

   import nanorv32_pkg::*;

   typedef enum logic [2:0] {
      st_reset_play,
      st_fetch_setup,
      st_fetch_access,
      st_seq_play,
      st_idle
   } state_t;

   state_t     state;
   state_t     state_nxt;
   // Kind of the sequence being played, picks the PC at its end
   useq_kind_t active_kind;

   // Next address to fetch, and its copy taken at interrupt entry
   logic [pc_width-1:0] pc;
   logic [pc_width-1:0] saved_pc;

   // Single output register
   logic                  out_valid;
   logic [data_width-1:0] out_word;
   logic [pc_width-1:0]   out_pc;
   inst_src_t             out_src;

   logic load_mem;
   logic load_rom;
   logic accept_mem;
   logic seq_done;

   // APB data phase completes
   assign load_mem   = (state == st_fetch_access) && apb_rsp.pready;
   // ROM word moves to the output only when the consumer can take the old one
   assign load_rom   = (state == st_seq_play) && urom_valid && inst_ready;
   assign seq_step   = load_rom;
   assign accept_mem = out_valid && inst_ready && (out_src == src_mem);
   // Sequencer drops busy once its last entry was taken
   assign seq_done   = (state == st_seq_play) && !seq_busy;

   // Next state and sequencer requests
   always_comb begin
      state_nxt = state;
      seq_start = 1'b0;
      seq_kind  = useq_none;
      irq_ack   = 1'b0;
      case (state)
         st_reset_play: begin
            // Reset sequence starts on the first cycle out of reset
            seq_start = 1'b1;
            seq_kind  = useq_reset;
            state_nxt = st_seq_play;
         end
         st_idle: begin
            if (irq_req || irq_ret) begin
               // Hold off fetching, wait for the output register to drain
               if (!out_valid) begin
                  seq_start = 1'b1;
                  seq_kind  = irq_req ? useq_entry : useq_exit;
                  irq_ack   = 1'b1;
                  state_nxt = st_seq_play;
               end
            end else if (inst_ready) begin
               // Any held word leaves on this edge, so setup may follow
               state_nxt = st_fetch_setup;
            end
         end
         st_fetch_setup: begin
            state_nxt = st_fetch_access;
         end
         st_fetch_access: begin
            if (apb_rsp.pready) begin
               state_nxt = st_idle;
            end
         end
         st_seq_play: begin
            if (seq_done) begin
               state_nxt = st_idle;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= st_reset_play;
         active_kind <= useq_none;
         pc          <= reset_vector;
         out_valid   <= 1'b0;
      end else begin
         state <= state_nxt;
         if (seq_start) begin
            active_kind <= seq_kind;
         end
         // PC redirect at the end of a sequence, else step per accepted memory word
         if (seq_done) begin
            case (active_kind)
               useq_entry: pc <= irq_vector;
               useq_exit:  pc <= saved_pc;
               default:    pc <= reset_vector;
            endcase
         end else if (accept_mem) begin
            pc <= pc + 32'd4;
         end
         out_valid <= load_mem || load_rom || (out_valid && !inst_ready);
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      // Output register is empty at entry, so pc is the next unfetched address
      if (seq_start && (seq_kind == useq_entry)) begin
         saved_pc <= pc;
      end
      if (load_mem) begin
         out_word <= apb_rsp.prdata;
         out_pc   <= pc;
         out_src  <= src_mem;
      end else if (load_rom) begin
         out_word <= urom_word;
         out_src  <= src_urom;
      end
   end

   // paddr holds pc, which only moves on acceptance outside a transfer
   assign apb_req = '{
      psel:    (state == st_fetch_setup) || (state == st_fetch_access),
      penable: (state == st_fetch_access),
      paddr:   pc
   };

   assign inst = '{valid: out_valid, word: out_word, pc: out_pc, src: out_src};

endmodule

`default_nettype wire

/* hdl/nanorv32_fetch_top.sv */
// Fetch front end top level joining the micro sequencer, micro ROM and fetch unit
`default_nettype none

module nanorv32_fetch_top (
   input  logic                       clk,
   input  logic                       rst_n,
   // Instruction memory
   output nanorv32_pkg::apb_req_t     apb_req,
   input  nanorv32_pkg::apb_rsp_t     apb_rsp,
   // Interrupt handshake
   input  logic                       irq_req,
   input  logic                       irq_ret,
   output logic                       irq_ack,
   // Stream to the decoder
   output nanorv32_pkg::inst_stream_t inst,
   input  logic                       inst_ready
);

   import nanorv32_pkg::*;

   // Sequencer handshake
   logic                  seq_start;
   useq_kind_t            seq_kind;
   logic                  seq_step;
   logic                  seq_busy;
   // ROM word path
   logic [data_width-1:0] urom_word;
   logic                  urom_valid;

   nanorv32_useq u_useq (
      .clk        (clk),
      .rst_n      (rst_n),
      .seq_start  (seq_start),
      .seq_kind   (seq_kind),
      .seq_step   (seq_step),
      .urom_word  (urom_word),
      .urom_valid (urom_valid),
      .seq_busy   (seq_busy)
   );

   nanorv32_ifetch u_ifetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .irq_req    (irq_req),
      .irq_ret    (irq_ret),
      .irq_ack    (irq_ack),
      .inst       (inst),
      .inst_ready (inst_ready),
      .seq_start  (seq_start),
      .seq_kind   (seq_kind),
      .seq_step   (seq_step),
      .urom_word  (urom_word),
      .urom_valid (urom_valid),
      .seq_busy   (seq_busy)
   );

endmodule

`default_nettype wire

/* test/nanorv32_fetch_chk.sv */
// Protocol checker for the fetch front end APB port, stream hold and interrupt acknowledge
`default_nettype none

module nanorv32_fetch_chk (
   input logic                       clk,
   input logic                       rst_n,
   input nanorv32_pkg::apb_req_t     apb_req,
   input nanorv32_pkg::apb_rsp_t     apb_rsp,
   input nanorv32_pkg::inst_stream_t inst,
   input logic                       inst_ready,
   input logic                       irq_ack
);

   // Sticky flags, one per property
   logic fail_setup = 1'b0;
   logic fail_addr  = 1'b0;
   logic fail_hold  = 1'b0;
   logic fail_ack   = 1'b0;
   logic fail_any;

   assign fail_any = fail_setup || fail_addr || fail_hold || fail_ack;

   // Setup phase is one cycle, then access
   setup_then_access: assert property (@(posedge clk) disable iff (!rst_n)
      apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
      else begin
         fail_setup = 1'b1;
         $error("APB setup cycle not followed by an access cycle");
      end

   // Address held from setup until pready
   addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
      apb_req.psel && !(apb_req.penable && apb_rsp.pready) |=> $stable(apb_req.paddr))
      else begin
         fail_addr = 1'b1;
         $error("APB paddr changed during a transfer");
      end

   // Stalled word keeps its contents
   stream_hold: assert property (@(posedge clk) disable iff (!rst_n)
      inst.valid && !inst_ready |=> inst.valid && $stable(inst.word)
         && $stable(inst.pc) && $stable(inst.src))
      else begin
         fail_hold = 1'b1;
         $error("Stream word changed while stalled");
      end

   // Acknowledge lasts exactly one cycle
   ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      irq_ack |=> !irq_ack)
      else begin
         fail_ack = 1'b1;
         $error("irq_ack held longer than one cycle");
      end

endmodule

bind nanorv32_fetch_top nanorv32_fetch_chk u_chk (
   .clk        (clk),
   .rst_n      (rst_n),
   .apb_req    (apb_req),
   .apb_rsp    (apb_rsp),
   .inst       (inst),
   .inst_ready (inst_ready),
   .irq_ack    (irq_ack)
);

`default_nettype wire

/* test/nanorv32_fetch_tb.sv */
// Testbench for the fetch front end, compares the stream with a golden list under APB wait states
`default_nettype none

module nanorv32_fetch_tb;

   import nanorv32_pkg::*;

   localparam int reset_cycles = 8;
   localparam int mem_words    = 64;
   // Header words after the memory image, then stream triples
   localparam int hdr_base     = 64;
   localparam int gold_base    = 67;
   localparam int gold_words   = 157;

   logic         clk;
   logic         rst_n;
   apb_req_t     apb_req;
   apb_rsp_t     apb_rsp;
   logic         irq_req;
   logic         irq_ret;
   logic         irq_ack;
   inst_stream_t inst;
   logic         inst_ready;

   logic [31:0] gold [0:255];
   logic [31:0] mem [0:mem_words-1];

   int n_words;
   int req_point;
   int ret_point;
   int accepted;
   int cycles;
   int limit;
   int wait_left;
   int acks;
   bit req_sent;
   bit ret_sent;
   bit ack_seen;

   nanorv32_fetch_top UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .irq_req    (irq_req),
      .irq_ret    (irq_ret),
      .irq_ack    (irq_ack),
      .inst       (inst),
      .inst_ready (inst_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("ERROR %s expected %08h actual %08h", name, expected, actual);
         $display("Checks failed");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   // Mid-cycle look at the outputs, a transfer happens on the next edge
   task automatic sample_outputs();
      logic [7:0] gidx;
      cycles++;
      if (cycles > limit) begin
         $display("Timeout: %0d of %0d stream words after %0d cycles", accepted, n_words, cycles);
         $display("Checks failed");
         $fatal(1, "timeout");
      end
      check_value("protocol assertions", 32'd0, {31'd0, UUT.u_chk.fail_any});
      // Port stays quiet while a ROM sequence plays or a ROM word waits
      check_value("apb quiet during rom", 32'd0,
                  {31'd0, apb_req.psel && (UUT.seq_busy || (inst.valid && inst.src == src_urom))});
      if (irq_ack) begin
         check_value("irq_ack with request", 32'd1, {31'd0, irq_req || irq_ret});
         ack_seen = 1'b1;
         acks++;
      end
      if (inst.valid && inst_ready) begin
         gidx = 8'(gold_base + 3 * accepted);
         check_value($sformatf("stream word %0d", accepted), gold[gidx], inst.word);
         check_value($sformatf("stream src %0d", accepted), gold[gidx + 8'd2], {31'd0, inst.src});
         // pc only carries meaning for memory words
         if (inst.src == src_mem) begin
            check_value($sformatf("stream pc %0d", accepted), gold[gidx + 8'd1], inst.pc);
            check_value($sformatf("memory data at %08h", inst.pc), mem[inst.pc[7:2]], inst.word);
         end
         accepted++;
      end
   endtask

   // New inputs just after the rising edge
   task automatic drive_inputs();
      // Consumer takes a word in about three cycles of four
      inst_ready = ($urandom % 4) != 0;
      apb_rsp.pready = 1'b0;
      apb_rsp.prdata = $urandom;
      if (apb_req.psel && !apb_req.penable) begin
         // Setup cycle, pick 0 to 3 wait states
         wait_left = $urandom % 4;
      end else if (apb_req.psel && apb_req.penable) begin
         check_value("apb address in range", 32'd0, {8'd0, apb_req.paddr[31:8]});
         if (wait_left == 0) begin
            apb_rsp.pready = 1'b1;
            apb_rsp.prdata = mem[apb_req.paddr[7:2]];
         end else begin
            wait_left--;
         end
      end
      // Requests are levels held until acknowledged
      if (ack_seen) begin
         irq_req  = 1'b0;
         irq_ret  = 1'b0;
         ack_seen = 1'b0;
      end
      if (!req_sent && accepted >= req_point) begin
         irq_req  = 1'b1;
         req_sent = 1'b1;
      end
      if (!ret_sent && accepted >= ret_point) begin
         irq_ret  = 1'b1;
         ret_sent = 1'b1;
      end
   endtask

   initial begin
      void'($urandom(37789));
      rst_n      = 1'b0;
      apb_rsp    = '0;
      irq_req    = 1'b0;
      irq_ret    = 1'b0;
      inst_ready = 1'b0;
      accepted   = 0;
      cycles     = 0;
      wait_left  = 0;
      acks       = 0;
      req_sent   = 1'b0;
      ret_sent   = 1'b0;
      ack_seen   = 1'b0;
      $readmemh("test/nanorv32_fetch_golden.txt", gold, 0, gold_words - 1);
      for (int i = 0; i < mem_words; i++) begin
         mem[i] = gold[i];
      end
      req_point = gold[hdr_base];
      ret_point = gold[hdr_base + 1];
      n_words   = gold[hdr_base + 2];
      // Budget of 40 cycles per expected word plus reset
      limit = 40 * n_words + reset_cycles;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;
      drive_inputs();
      while (accepted < n_words) begin
         @(negedge clk);
         sample_outputs();
         @(posedge clk);
         #1;
         drive_inputs();
      end
      // Let the last transfer edge go through the checker
      @(negedge clk);
      // One acknowledge for the entry request and one for the return
      check_value("irq_ack count", 32'd2, acks);
      if (!UUT.u_chk.fail_any) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("Protocol assertion failed on the last transfer");
         $display("Checks failed");
         $fatal(1, "assertion failure");
      end
   end

endmodule

`default_nettype wire

/* test/nanorv32_fetch_golden.txt */
// Words 0-63 memory image at byte address 4*i, then irq_req point, irq_ret point, stream length
// Stream entries follow as word, pc, src triples, src 0 for memory and 1 for micro ROM
c0de0000 c0de0004 c0de0008 c0de000c c0de0010 c0de0014 c0de0018 c0de001c
c0de0020 c0de0024 c0de0028 c0de002c c0de0030 c0de0034 c0de0038 c0de003c
c0de0040 c0de0044 c0de0048 c0de004c c0de0050 c0de0054 c0de0058 c0de005c
c0de0060 c0de0064 c0de0068 c0de006c c0de0070 c0de0074 c0de0078 c0de007c
c0de0080 c0de0084 c0de0088 c0de008c c0de0090 c0de0094 c0de0098 c0de009c
c0de00a0 c0de00a4 c0de00a8 c0de00ac c0de00b0 c0de00b4 c0de00b8 c0de00bc
c0de00c0 c0de00c4 c0de00c8 c0de00cc c0de00d0 c0de00d4 c0de00d8 c0de00dc
c0de00e0 c0de00e4 c0de00e8 c0de00ec c0de00f0 c0de00f4 c0de00f8 c0de00fc
00000004 00000018 0000001e
// Reset sequence, then memory from the reset vector
00100093 00000000 1   00000013 00000000 1
c0de0000 00000000 0   c0de0004 00000004 0
// Fetch already under way when irq_req rises
c0de0008 00000008 0
// Interrupt entry sequence, ROM entries 2-18
fe112e23 00000000 1   fe212c23 00000000 1
fe512a23 00000000 1   fe612823 00000000 1
fe712623 00000000 1   fea12423 00000000 1
feb12223 00000000 1   fec12023 00000000 1
fcd12e23 00000000 1   fce12c23 00000000 1
fcf12a23 00000000 1   fff00093 00000000 1
00000097 00000000 1   fc112823 00000000 1
fd010113 00000000 1   08002103 00000000 1
00010067 00000000 1
// Handler code from the interrupt vector
c0de0040 00000040 0   c0de0044 00000044 0
c0de0048 00000048 0
// Interrupt exit sequence, ROM entries 19-20
00300093 00000000 1   00000013 00000000 1
// Resume after the last word taken before entry
c0de000c 0000000c 0   c0de0010 00000010 0
c0de0014 00000014 0

/* list.f */
hdl/nanorv32_pkg.sv
hdl/nanorv32_urom.sv
hdl/nanorv32_useq.sv
hdl/nanorv32_ifetch.sv
hdl/nanorv32_fetch_top.sv
test/nanorv32_fetch_chk.sv
test/nanorv32_fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nanorv32_fetch_tb -f list.f -o fetch_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/fetch_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
